// ==== source/evb_pkg.sv ====
package evb_pkg;

    // number of readout links feeding the builder
    localparam int num_links = 4;

    // one payload byte per link beat
    localparam int data_width = 8;

    // enough bits to name any link on the output
    localparam int link_id_width = 2;

    // words per link buffer
    // two maximum fragments fit so a link can run one event ahead
    localparam int link_fifo_depth = 32;

    // longest fragment a link is allowed to send
    localparam int max_fragment_words = 16;

    // small skid stage in front of the output port
    localparam int out_fifo_depth = 4;

    // word as stored in a link buffer
    typedef struct packed {
        logic [data_width-1:0] data;
        logic                  last;
    } link_word_t;

    // merged word
    // link_id tags the source link, last marks the end of the event
    typedef struct packed {
        logic [data_width-1:0]    data;
        logic [link_id_width-1:0] link_id;
        logic                     last;
    } out_word_t;

endpackage

// ==== source/sync_fifo.sv ====
module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 4
) (
    input  logic     aclk,
    input  logic     aresetn,

    // write side
    input  logic     wr_en,
    input  payload_t wr_data,
    output logic     full,

    // read side, head word is presented while not empty
    input  logic     rd_en,
    output payload_t rd_data,
    output logic     empty
);

    // storage array
    payload_t mem [depth];

    logic [$clog2(depth)-1:0] wr_ptr;
    logic [$clog2(depth)-1:0] rd_ptr;
    // number of words held, 0 up to depth
    logic [$clog2(depth+1)-1:0] count;

    logic do_wr;
    logic do_rd;

    // requests are only honoured when they can complete
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    assign full  = (int'(count) == depth);
    assign empty = (count == '0);

    // first word fall through
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge aclk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap at depth, which need not be a power of two
            if (do_wr) begin
                if (int'(wr_ptr) == depth - 1) wr_ptr <= '0;
                else wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                if (int'(rd_ptr) == depth - 1) rd_ptr <= '0;
                else rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous read and write leaves the count alone
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== source/event_completion_tracker.sv ====
module event_completion_tracker (
    input  logic                          aclk,
    input  logic                          aresetn,

    // raw input link handshake signals
    input  logic [evb_pkg::num_links-1:0] s_axis_tlast,
    input  logic [evb_pkg::num_links-1:0] s_axis_tvalid,
    input  logic [evb_pkg::num_links-1:0] s_axis_tready,
    // a set bit disables that link
    input  logic [evb_pkg::num_links-1:0] tio_mask,

    output logic                          complete_o,
    output logic [evb_pkg::num_links-1:0] err_o,
    output logic [evb_pkg::num_links-1:0] active_o
);

    import evb_pkg::*;

    // links that already delivered tlast for the current event
    logic [num_links-1:0] complete_seen;
    logic [num_links-1:0] active;
    logic                 complete;
    logic [num_links-1:0] last_hs;
    logic [num_links-1:0] err_in;
    logic                 err_latched;
    logic [num_links-1:0] err;

    // accepted tlast beats on links that take part
    assign last_hs = s_axis_tlast & s_axis_tvalid & s_axis_tready & active;

    // second tlast on a link before the event closed
    // during the pulse the event is closed and a tlast starts the next one
    assign err_in = last_hs & complete_seen & ~{num_links{complete}};

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            active        <= '0;
            complete      <= 1'b0;
            complete_seen <= '0;
            err_latched   <= 1'b0;
            err           <= '0;
        end else begin
            // active set is the registered inverse of the mask
            active <= ~tio_mask;

            // one cycle pulse once the record matches the active set
            // an empty active set never completes
            complete <= (|active) && (complete_seen == active) && !complete;

            // a new tlast wins over the clear at the end of the pulse
            for (int i = 0; i < num_links; i++) begin
                if (last_hs[i]) complete_seen[i] <= 1'b1;
                else if (complete) complete_seen[i] <= 1'b0;
            end

            // keep only the first violation
            // stored value names the active links that had not finished,
            // they are the ones presumed to have lost data
            if (|err_in && !err_latched) begin
                err_latched <= 1'b1;
                err         <= ~complete_seen & active;
            end
        end
    end

    assign complete_o = complete;
    assign err_o      = err;
    assign active_o   = active;

endmodule

// ==== source/event_merger.sv ====
module event_merger (
    input  logic                                      aclk,
    input  logic                                      aresetn,

    // event tokens from the tracker
    input  logic                                      complete,
    input  logic [evb_pkg::num_links-1:0]             active,

    // link buffer heads
    input  evb_pkg::link_word_t [evb_pkg::num_links-1:0] link_data,
    input  logic [evb_pkg::num_links-1:0]             link_empty,
    output logic [evb_pkg::num_links-1:0]             link_rd,

    // output buffer write side
    output logic                                      out_wr,
    output evb_pkg::out_word_t                        out_data,
    input  logic                                      out_full
);

    import evb_pkg::*;

    // completed events still waiting to be drained
    // link buffers bound how many can be outstanding
    logic [$clog2(link_fifo_depth+1):0] pending;

    // high while an event is being copied out
    logic busy;
    // link currently being drained
    logic [link_id_width-1:0] cur_link;

    logic       cur_active;
    link_word_t head;
    logic       higher_active;
    logic       can_move;
    logic       event_done;
    logic       token_in;

    // no active link means tokens carry no data
    assign token_in = complete && (|active);

    assign cur_active = active[cur_link];
    assign head       = link_data[cur_link];

    // is there an active link above the current one
    always_comb begin
        higher_active = 1'b0;
        for (int i = 0; i < num_links; i++) begin
            if (i > int'(cur_link) && active[i]) higher_active = 1'b1;
        end
    end

    // one word moves per cycle when the head is there and the output has room
    assign can_move = busy && cur_active && !link_empty[cur_link] && !out_full;

    // final word of the highest active link closes the event
    assign event_done = can_move && head.last && !higher_active;

    always_comb begin
        link_rd           = '0;
        link_rd[cur_link] = can_move;
    end

    assign out_wr = can_move;

    always_comb begin
        out_data.data    = head.data;
        out_data.link_id = cur_link;
        // only the event's last word carries tlast downstream
        out_data.last    = head.last && !higher_active;
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            pending <= '0;
        end else begin
            case ({token_in, event_done})
                2'b10:   pending <= pending + 1'b1;
                2'b01:   pending <= pending - 1'b1;
                default: pending <= pending;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            busy     <= 1'b0;
            cur_link <= '0;
        end else if (!busy) begin
            // start every event at link 0 and walk upward
            if (pending != '0) begin
                busy     <= 1'b1;
                cur_link <= '0;
            end
        end else if (!cur_active) begin
            // masked link, step past it
            cur_link <= cur_link + 1'b1;
        end else if (can_move && head.last) begin
            if (higher_active) begin
                cur_link <= cur_link + 1'b1;
            end else begin
                // event finished, recheck the counter next cycle
                busy     <= 1'b0;
                cur_link <= '0;
            end
        end
    end

endmodule

// ==== source/event_builder_top.sv ====
module event_builder_top (
    input  logic                                                  aclk,
    input  logic                                                  aresetn,

    // static link disable, set bit masks a link
    input  logic [evb_pkg::num_links-1:0]                         tio_mask,

    // input links
    input  logic [evb_pkg::num_links-1:0][evb_pkg::data_width-1:0] s_axis_tdata,
    input  logic [evb_pkg::num_links-1:0]                         s_axis_tvalid,
    input  logic [evb_pkg::num_links-1:0]                         s_axis_tlast,
    output logic [evb_pkg::num_links-1:0]                         s_axis_tready,

    // merged output stream, tuser carries the link id
    output logic [evb_pkg::data_width-1:0]                        m_axis_tdata,
    output logic [evb_pkg::link_id_width-1:0]                     m_axis_tuser,
    output logic                                                  m_axis_tlast,
    output logic                                                  m_axis_tvalid,
    input  logic                                                  m_axis_tready,

    // sticky double tlast error
    output logic [evb_pkg::num_links-1:0]                         event_err
);

    import evb_pkg::*;

    logic                 complete;
    logic [num_links-1:0] active;

    link_word_t [num_links-1:0] link_in;
    link_word_t [num_links-1:0] link_head;
    logic [num_links-1:0]       link_wr;
    logic [num_links-1:0]       link_full;
    logic [num_links-1:0]       link_empty;
    logic [num_links-1:0]       link_rd;

    logic      out_wr;
    out_word_t out_wr_data;
    logic      out_full;
    logic      out_empty;
    out_word_t out_head;

    event_completion_tracker u_tracker (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .s_axis_tlast  (s_axis_tlast),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .tio_mask      (tio_mask),
        .complete_o    (complete),
        .err_o         (event_err),
        .active_o      (active)
    );

    // one buffer per link, ready only reflects buffer space
    for (genvar n = 0; n < num_links; n++) begin : g_link
        assign s_axis_tready[n] = !link_full[n];
        // masked links are accepted and dropped
        assign link_wr[n]      = s_axis_tvalid[n] && !tio_mask[n] && !link_full[n];
        assign link_in[n].data = s_axis_tdata[n];
        assign link_in[n].last = s_axis_tlast[n];

        sync_fifo #(
            .payload_t (link_word_t),
            .depth     (link_fifo_depth)
        ) u_link_fifo (
            .aclk    (aclk),
            .aresetn (aresetn),
            .wr_en   (link_wr[n]),
            .wr_data (link_in[n]),
            .full    (link_full[n]),
            .rd_en   (link_rd[n]),
            .rd_data (link_head[n]),
            .empty   (link_empty[n])
        );
    end

    event_merger u_merger (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .complete   (complete),
        .active     (active),
        .link_data  (link_head),
        .link_empty (link_empty),
        .link_rd    (link_rd),
        .out_wr     (out_wr),
        .out_data   (out_wr_data),
        .out_full   (out_full)
    );

    // skid stage between merger and output port
    sync_fifo #(
        .payload_t (out_word_t),
        .depth     (out_fifo_depth)
    ) u_out_fifo (
        .aclk    (aclk),
        .aresetn (aresetn),
        .wr_en   (out_wr),
        .wr_data (out_wr_data),
        .full    (out_full),
        .rd_en   (m_axis_tvalid && m_axis_tready),
        .rd_data (out_head),
        .empty   (out_empty)
    );

    assign m_axis_tvalid = !out_empty;
    assign m_axis_tdata  = out_head.data;
    assign m_axis_tuser  = out_head.link_id;
    assign m_axis_tlast  = out_head.last;

endmodule

// ==== verif/tb_event_builder.sv ====
module tb_event_builder;

    import evb_pkg::*;

    localparam int stim_size = 256;
    localparam int exp_width = data_width + link_id_width + 1;

    logic                                 aclk;
    logic                                 aresetn;
    logic [num_links-1:0]                 tio_mask;
    logic [num_links-1:0][data_width-1:0] s_axis_tdata;
    logic [num_links-1:0]                 s_axis_tvalid;
    logic [num_links-1:0]                 s_axis_tlast;
    logic [num_links-1:0]                 s_axis_tready;
    logic [data_width-1:0]                m_axis_tdata;
    logic [link_id_width-1:0]             m_axis_tuser;
    logic                                 m_axis_tlast;
    logic                                 m_axis_tvalid;
    logic                                 m_axis_tready;
    logic [num_links-1:0]                 event_err;

    // records T L CC DD, layout described at the top of the stimulus file
    logic [23:0] stim [stim_size];
    // words still to drive per link, {data, last}
    logic [data_width:0] link_q [num_links][$];
    // expected output words, {data, link id, last}
    logic [exp_width-1:0] exp_q [$];

    // accepted input words and seen output words per link
    int   wr_cnt [num_links];
    int   out_cnt [num_links];
    int   errors = 0;
    int   cycle_limit = 0;
    int   cycle_count = 0;
    logic random_mode;

    event_builder_top u_dut (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .tio_mask      (tio_mask),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tlast  (s_axis_tlast),
        .s_axis_tready (s_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tuser  (m_axis_tuser),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .event_err     (event_err)
    );

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    // watchdog, armed once the stimulus size is known
    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge aclk);
            cycle_count++;
        end
        $display("timeout: run stopped after %0d cycles", cycle_count);
        $display("errors: %0d", errors);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // next falling edge, then check ready and serve the output port
    task automatic tick();
        logic [exp_width-1:0] exp;
        @(negedge aclk);
        // a link may only stall once it really holds a full buffer
        for (int n = 0; n < num_links; n++) begin
            if (!s_axis_tready[n] && (wr_cnt[n] - out_cnt[n]) < link_fifo_depth) begin
                errors++;
                $display("at %0t s_axis_tready[%0d] low with only %0d unread words",
                         $time, n, wr_cnt[n] - out_cnt[n]);
            end
        end
        m_axis_tready = random_mode ? (($urandom % 2) == 1) : 1'b1;
        if (m_axis_tvalid && m_axis_tready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("at %0t extra output word, data %h tuser %0d",
                         $time, m_axis_tdata, m_axis_tuser);
            end else begin
                exp = exp_q.pop_front();
                if (m_axis_tdata !== exp[exp_width-1:link_id_width+1]) begin
                    errors++;
                    $display("mismatch at %0t: m_axis_tdata expected %h actual %h",
                             $time, exp[exp_width-1:link_id_width+1], m_axis_tdata);
                end
                if (m_axis_tuser !== exp[link_id_width:1]) begin
                    errors++;
                    $display("mismatch at %0t: m_axis_tuser expected %0d actual %0d",
                             $time, exp[link_id_width:1], m_axis_tuser);
                end
                if (m_axis_tlast !== exp[0]) begin
                    errors++;
                    $display("mismatch at %0t: m_axis_tlast expected %b actual %b",
                             $time, exp[0], m_axis_tlast);
                end
            end
            out_cnt[m_axis_tuser]++;
        end
    endtask

    task automatic apply_reset(logic [num_links-1:0] mask);
        @(negedge aclk);
        aresetn       = 1'b0;
        tio_mask      = mask;
        s_axis_tvalid = '0;
        s_axis_tlast  = '0;
        s_axis_tdata  = '0;
        m_axis_tready = 1'b0;
        for (int n = 0; n < num_links; n++) begin
            wr_cnt[n]  = 0;
            out_cnt[n] = 0;
        end
        repeat (5) @(negedge aclk);
        aresetn = 1'b1;
        @(negedge aclk);
        if (m_axis_tvalid !== 1'b0) begin
            errors++;
            $display("mismatch at %0t: m_axis_tvalid expected 0 actual %b", $time, m_axis_tvalid);
        end
        if (event_err !== '0) begin
            errors++;
            $display("mismatch at %0t: event_err expected 0000 actual %b", $time, event_err);
        end
        if (s_axis_tready !== '1) begin
            errors++;
            $display("mismatch at %0t: s_axis_tready expected 1111 actual %b",
                     $time, s_axis_tready);
        end
        // mask settles for two cycles before any data
        @(negedge aclk);
    endtask

    task automatic queue_words(logic [23:0] rec);
        int                    cnt;
        logic [data_width-1:0] data;
        cnt  = int'(rec[15:8]);
        data = rec[7:0];
        for (int i = 0; i < cnt; i++) begin
            link_q[rec[17:16]].push_back({data, (rec[23:20] == 4'h3) && (i == cnt - 1)});
            data++;
        end
    endtask

    // words not yet driven, summed over all links
    function automatic int words_left();
        int total;
        total = 0;
        for (int n = 0; n < num_links; n++) begin
            total += link_q[n].size();
        end
        return total;
    endfunction

    // merge rule: per event, active links in ascending order,
    // tlast only on the final word of the highest active link
    task automatic build_expected();
        int                  idx [num_links];
        int                  top;
        int                  len;
        logic                more;
        logic [data_width:0] w;
        top = -1;
        for (int n = 0; n < num_links; n++) begin
            idx[n] = 0;
            if (!tio_mask[n]) top = n;
        end
        more = (top >= 0);
        while (more) begin
            more = 1'b0;
            for (int n = 0; n < num_links; n++) begin
                w   = '0;
                len = 0;
                while (!tio_mask[n] && !w[0] && idx[n] < link_q[n].size()) begin
                    w = link_q[n][idx[n]];
                    idx[n]++;
                    len++;
                    exp_q.push_back({w[data_width:1], 2'(n), w[0] && (n == top)});
                end
                // fragments beyond the allowed length would overrun the buffers
                if (len > max_fragment_words) begin
                    errors++;
                    $display("stimulus fragment on link %0d has %0d words, limit is %0d",
                             n, len, max_fragment_words);
                end
                if (!tio_mask[n] && idx[n] < link_q[n].size()) more = 1'b1;
            end
        end
    endtask

    // all links run one event at a time, in parallel
    task automatic run_group();
        logic [num_links-1:0] done;
        logic [data_width:0]  w;
        while (words_left() > 0) begin
            for (int n = 0; n < num_links; n++) begin
                done[n] = (link_q[n].size() == 0);
            end
            while (done != '1) begin
                tick();
                for (int n = 0; n < num_links; n++) begin
                    if (!done[n] && (!random_mode || ($urandom % 4) != 0)) begin
                        w                = link_q[n][0];
                        s_axis_tvalid[n] = 1'b1;
                        s_axis_tdata[n]  = w[data_width:1];
                        s_axis_tlast[n]  = w[0];
                        // ready does not depend on valid, so this edge takes the word
                        if (s_axis_tready[n]) begin
                            w = link_q[n].pop_front();
                            if (!tio_mask[n]) wr_cnt[n]++;
                            if (w[0]) done[n] = 1'b1;
                        end
                    end else begin
                        s_axis_tvalid[n] = 1'b0;
                    end
                end
            end
            // complete_seen clears two edges after the last tlast
            repeat (3) begin
                tick();
                s_axis_tvalid = '0;
            end
        end
        while (exp_q.size() != 0) tick();
        // catch stray words after the model is exhausted
        repeat (20) tick();
    endtask

    // error scenario, one word per cycle in file order
    task automatic drive_in_order(logic [23:0] rec);
        int                    n;
        int                    cnt;
        logic [data_width-1:0] data;
        n    = int'(rec[17:16]);
        cnt  = int'(rec[15:8]);
        data = rec[7:0];
        for (int i = 0; i < cnt; i++) begin
            tick();
            s_axis_tvalid    = '0;
            s_axis_tvalid[n] = 1'b1;
            s_axis_tdata[n]  = data;
            s_axis_tlast[n]  = (rec[23:20] == 4'h3) && (i == cnt - 1);
            while (!s_axis_tready[n]) tick();
            if (!tio_mask[n]) wr_cnt[n]++;
            data++;
        end
        tick();
        s_axis_tvalid = '0;
    endtask

    initial begin
        logic [23:0] rec;
        int          idx;
        int          total_words;
        aresetn       = 1'b0;
        tio_mask      = '0;
        s_axis_tdata  = '0;
        s_axis_tvalid = '0;
        s_axis_tlast  = '0;
        m_axis_tready = 1'b0;
        random_mode   = 1'b0;
        void'($urandom(53));
        // unused entries read as end records
        for (int i = 0; i < stim_size; i++) stim[i] = {4'hf, 20'(i)};
        $readmemh("verif/event_stimulus.txt", stim);
        total_words = 0;
        for (int i = 0; i < stim_size; i++) begin
            if (stim[i][23:20] == 4'h2 || stim[i][23:20] == 4'h3) begin
                total_words += int'(stim[i][15:8]);
            end
        end
        cycle_limit = 40 * total_words + 200;
        idx = 0;
        while (idx < stim_size && stim[idx][23:20] != 4'hf) begin
            rec = stim[idx];
            idx++;
            case (rec[23:20])
                4'h1: begin
                    random_mode = rec[16];
                    apply_reset(rec[num_links-1:0]);
                    // gather the group's words per link
                    while (idx < stim_size && stim[idx][23:21] == 3'b001) begin
                        queue_words(stim[idx]);
                        idx++;
                    end
                    build_expected();
                    run_group();
                end
                4'h4: begin
                    random_mode = 1'b0;
                    apply_reset(rec[num_links-1:0]);
                end
                4'h2, 4'h3: drive_in_order(rec);
                4'h5: begin
                    repeat (3) tick();
                    if (event_err !== rec[num_links-1:0]) begin
                        errors++;
                        $display("mismatch at %0t: event_err expected %b actual %b",
                                 $time, rec[num_links-1:0], event_err);
                    end
                end
                default: begin
                    errors++;
                    $display("unknown stimulus record %h at entry %0d", rec, idx - 1);
                end
            endcase
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verif/event_stimulus.txt ====
// one record per line, hex T L CC DD: type, link, word count, first data byte
// T 1 group (L 0 steady, 1 random; DD mask), 2 words, 3 words ending in tlast,
// T 4 error group (DD mask), 5 expected event_err (DD), f end; data counts up
// group 1: all links active, no gaps, output always ready
100000
300310
310120
200230
320134
330440
300150
310260
320170
330280
// group 2: links 0 and 2 masked, their words must not appear
100005
3002a0
3102b0
3201c0
3303d0
3001e0
3101e8
3202f0
3301f8
// group 3: random gaps and output stalls, fragments up to 16 words
110000
301000
310520
321040
331060
300880
311090
3210a0
3303b0
3010c0
3110d0
3201e0
3310f0
// group 4: random, link 3 masked
110008
300401
310109
320310
330518
// error group: link 0 sends again before link 2 ends, links 0 and 1 had finished
400000
300101
310211
220121
300131
50000c
// second violation on link 1 leaves event_err unchanged
310141
50000c
f00000

// ==== sim.f ====
source/evb_pkg.sv
source/sync_fifo.sv
source/event_completion_tracker.sv
source/event_merger.sv
source/event_builder_top.sv
verif/tb_event_builder.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_event_builder
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
FAIL_MSG  ?= *** TEST FAILED ***
PASS_MSG  ?= *** TEST PASSED ***

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
